//--- logic/bin_to_bcd.sv
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd
	import num_fmt_pkg::*;
#(
	parameter int BIN_BITS = DEF_BIN_BITS
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               start,
	input  wire  [BIN_BITS-1:0]               bin_value,
	output logic                              busy,
	output logic                              done,
	output logic [4*bcd_digits(BIN_BITS)-1:0] bcd
);

	localparam int DIGITS  = bcd_digits(BIN_BITS);
	localparam int BCD_W   = 4 * DIGITS;
	localparam int COUNT_W = count_bits(BIN_BITS);

	typedef enum logic [2:0] {
		ST_IDLE    = 3'b001,
		ST_CONVERT = 3'b010,
		ST_OUTPUT  = 3'b100
	} state_t;

	state_t              state;
	state_t              next_state;
	logic [COUNT_W-1:0]  count;
	logic [BIN_BITS-1:0] bin_reg;
	logic [BCD_W-1:0]    shift_reg;
	logic [BCD_W-1:0]    adjusted;

	// --------------------
	// Add-three correction
	// --------------------

	always_comb begin
		for (int i = 0; i < DIGITS; i++) begin
			if (shift_reg[i*4 +: 4] >= 4'd5) begin
				adjusted[i*4 +: 4] = shift_reg[i*4 +: 4] + 4'd3;
			end else begin
				adjusted[i*4 +: 4] = shift_reg[i*4 +: 4];
			end
		end
	end

	// --------------------
	// Controller
	// --------------------

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					next_state = ST_CONVERT;
				end
			end
			ST_CONVERT: begin
				if (count == COUNT_W'(BIN_BITS - 1)) begin
					next_state = ST_OUTPUT;	// Last shift happens on this edge.
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	assign busy = (state != ST_IDLE);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
			done  <= 1'b0;
			bcd   <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					count <= '0;
				end
				ST_CONVERT: begin
					count <= count + 1'b1;
				end
				ST_OUTPUT: begin
					bcd  <= shift_reg;
					done <= 1'b1;
				end
				default: begin
					count <= '0;
				end
			endcase
		end
	end

	// --------------------
	// Shift path
	// --------------------

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				bin_reg   <= bin_value;	// Sampled on the same edge as start.
				shift_reg <= '0;
			end
			ST_CONVERT: begin
				{shift_reg, bin_reg} <= {adjusted[BCD_W-2:0], bin_reg, 1'b0};
			end
			default: begin
				shift_reg <= shift_reg;
			end
		endcase
	end

	function automatic logic digits_valid(input logic [BCD_W-1:0] value);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < DIGITS; i++) begin
			if (value[i*4 +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	a_done_single: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done held high for more than one cycle");

	a_bcd_decimal: assert property (@(posedge clk) disable iff (!rst)
		done |-> digits_valid(bcd))
		else $error("bcd holds a nibble above nine at done");

endmodule

`default_nettype wire

//--- logic/digit_scan.sv
`timescale 1ns/10ps
`default_nettype none

module digit_scan
	import num_fmt_pkg::*, disp_pkg::*;
#(
	parameter int BIN_BITS = DEF_BIN_BITS,
	parameter int SCAN_DIV = DEF_SCAN_DIV
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               load,
	input  wire  [4*bcd_digits(BIN_BITS)-1:0] bcd,
	output logic [SEG_BITS-1:0]               seg,
	output logic [bcd_digits(BIN_BITS)-1:0]   digit_sel
);

	localparam int DIGITS  = bcd_digits(BIN_BITS);
	localparam int BCD_W   = 4 * DIGITS;
	localparam int DWELL_W = count_bits(SCAN_DIV);
	localparam int POS_W   = count_bits(DIGITS);

	logic [BCD_W-1:0]   shown;
	logic [DIGITS-1:0]  blank;
	logic [DIGITS-1:0]  blank_next;
	logic [DWELL_W-1:0] dwell;
	logic [POS_W-1:0]   pos;

	// --------------------
	// Leading-zero blanking
	// --------------------

	// Walk down from the top digit until the first nonzero nibble.
	always_comb begin : lead_zero
		logic seen;
		seen       = 1'b0;
		blank_next = '0;
		for (int i = DIGITS - 1; i > 0; i--) begin
			if (bcd[i*4 +: 4] != 4'd0) begin
				seen = 1'b1;
			end
			blank_next[i] = !seen;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			blank <= '1;	// Dark display until the first result arrives.
		end else if (load) begin
			blank <= blank_next;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			shown <= bcd;
		end
	end

	// --------------------
	// Digit scan
	// --------------------

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dwell <= '0;
			pos   <= '0;
		end else if (dwell == DWELL_W'(SCAN_DIV - 1)) begin
			dwell <= '0;
			if (pos == POS_W'(DIGITS - 1)) begin
				pos <= '0;	// Wrap back to digit 0.
			end else begin
				pos <= pos + 1'b1;
			end
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	assign digit_sel = DIGITS'(1) << pos;

	assign seg = blank[pos] ? SEG_OFF : seg_pattern(shown[pos*4 +: 4]);

	a_sel_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot(digit_sel))
		else $error("digit_sel is not one-hot");

endmodule

`default_nettype wire

//--- logic/disp_pkg.sv
`default_nettype none

package disp_pkg;

	// --------------------
	// Segment constants
	// --------------------

	localparam int SEG_BITS = 7;	// Segments g down to a.

	localparam logic [SEG_BITS-1:0] SEG_OFF = 7'b000_0000;	// All segments dark.

	// --------------------
	// Scan timing
	// --------------------

	localparam int DEF_SCAN_DIV = 4;	// Clocks each digit stays selected.

	// --------------------
	// Segment table
	// --------------------

	// Active-high pattern, bit 6 is segment g and bit 0 is segment a.
	function automatic logic [SEG_BITS-1:0] seg_pattern(input logic [3:0] nibble);
		logic [SEG_BITS-1:0] pattern;
		case (nibble)
			4'd0: pattern = 7'b011_1111;
			4'd1: pattern = 7'b000_0110;
			4'd2: pattern = 7'b101_1011;
			4'd3: pattern = 7'b100_1111;
			4'd4: pattern = 7'b110_0110;
			4'd5: pattern = 7'b110_1101;
			4'd6: pattern = 7'b111_1101;
			4'd7: pattern = 7'b000_0111;
			4'd8: pattern = 7'b111_1111;
			4'd9: pattern = 7'b110_1111;
			default: begin
				pattern = SEG_OFF;	// Codes 10 to 15 are not decimal.
			end
		endcase
		return pattern;
	endfunction

endpackage

`default_nettype wire

//--- logic/num_fmt_pkg.sv
`default_nettype none

package num_fmt_pkg;

	// --------------------
	// Binary input defaults
	// --------------------

	localparam int DEF_BIN_BITS = 10;	// Covers 0 to 1023.

	// --------------------
	// Width rules
	// --------------------

	// Number of decimal digits needed for the largest unsigned value of bin_bits.
	function automatic int bcd_digits(input int bin_bits);
		longint max_val;
		int     digits;
		max_val = (longint'(1) << bin_bits) - 1;
		digits  = 0;
		while (max_val > 0) begin
			digits  = digits + 1;
			max_val = max_val / 10;
		end
		if (digits == 0) begin
			digits = 1;	// A zero-width input still shows one digit.
		end
		return digits;
	endfunction

	// Ceiling of log2, never below one bit so that counters stay legal.
	function automatic int count_bits(input int bin_bits);
		int width;
		width = 0;
		while ((1 << width) < bin_bits) begin
			width = width + 1;
		end
		if (width < 1) begin
			width = 1;
		end
		return width;
	endfunction

endpackage

`default_nettype wire

//--- logic/readout_top.sv
`timescale 1ns/10ps
`default_nettype none

module readout_top
	import num_fmt_pkg::*, disp_pkg::*;
#(
	parameter int BIN_BITS = DEF_BIN_BITS,
	parameter int SCAN_DIV = DEF_SCAN_DIV
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               start,
	input  wire  [BIN_BITS-1:0]               bin_value,
	output logic                              busy,
	output logic                              done,
	output logic [4*bcd_digits(BIN_BITS)-1:0] bcd,
	output logic [SEG_BITS-1:0]               seg,
	output logic [bcd_digits(BIN_BITS)-1:0]   digit_sel
);

	// --------------------
	// Converter
	// --------------------

	bin_to_bcd #(
		.BIN_BITS (BIN_BITS)
	) u_bin_to_bcd (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.bin_value (bin_value),
		.busy      (busy),
		.done      (done),
		.bcd       (bcd)
	);

	// --------------------
	// Display
	// --------------------

	// The done pulse loads each new result into the scanner.
	digit_scan #(
		.BIN_BITS (BIN_BITS),
		.SCAN_DIV (SCAN_DIV)
	) u_digit_scan (
		.clk       (clk),
		.rst       (rst),
		.load      (done),
		.bcd       (bcd),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the readout testbench with Verilator and runs it.
# The simulator exits nonzero on any $fatal, which fails this script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_readout \
	-f vlog.f \
	-o tb_readout

./obj_dir/tb_readout

//--- tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;	// 20 ns period.
		end
	end

	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b1;	// Released just after an edge, like the other inputs.
	end

endmodule

`default_nettype wire

//--- tests/tb_readout.sv
`timescale 1ns/10ps
`default_nettype none

module tb_readout;

	localparam int BIN_BITS = 10;
	localparam int SCAN_DIV = 4;

	// Counts the decimal digits of a non-negative value and returns at least one.
	function automatic int num_digits(input int value);
		int n;
		n = 1;
		while (value >= 10) begin
			value = value / 10;
			n     = n + 1;
		end
		return n;
	endfunction

	localparam int DIGITS   = num_digits((1 << BIN_BITS) - 1);
	localparam int BCD_W    = 4 * DIGITS;
	localparam int N_FIXED  = 7;
	localparam int N_RANDOM = 200;
	localparam int N_CONV   = N_FIXED + N_RANDOM + 1;
	localparam int LIMIT    = 2 * (N_CONV * (BIN_BITS + 2 + 4) + 2000);

	localparam logic [6:0] DARK = 7'h00;

	logic                clk;
	logic                rst;
	logic                start;
	logic [BIN_BITS-1:0] bin_value;
	logic                busy;
	logic                done;
	logic [BCD_W-1:0]    bcd;
	logic [6:0]          seg;
	logic [DIGITS-1:0]   digit_sel;

	logic [BCD_W-1:0] pending[$];	// Expected words of accepted conversions.
	logic [BCD_W-1:0] disp_word  = '0;
	logic             disp_valid = 1'b0;
	int               scan_pos    = 0;
	int               scan_dwell  = 0;
	int               cycle_count = 0;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	readout_top #(
		.BIN_BITS (BIN_BITS),
		.SCAN_DIV (SCAN_DIV)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.bin_value (bin_value),
		.busy      (busy),
		.done      (done),
		.bcd       (bcd),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

	// --------------------
	// Reference model
	// --------------------

	// Active-high segment patterns with g in bit 6 and a in bit 0.
	function automatic logic [6:0] seg_ref(input int digit);
		case (digit)
			0: return 7'h3f;
			1: return 7'h06;
			2: return 7'h5b;
			3: return 7'h4f;
			4: return 7'h66;
			5: return 7'h6d;
			6: return 7'h7d;
			7: return 7'h07;
			8: return 7'h7f;
			9: return 7'h6f;
			default: return DARK;
		endcase
	endfunction

	function automatic logic [BCD_W-1:0] to_bcd(input int value);
		logic [BCD_W-1:0] word;
		int               rest;
		rest = value;
		word = '0;
		for (int i = 0; i < DIGITS; i++) begin
			word[i*4 +: 4] = 4'(rest % 10);
			rest           = rest / 10;
		end
		return word;
	endfunction

	// A digit above 0 is dark when it and every digit above it are zero.
	function automatic logic [6:0] exp_seg(input logic [BCD_W-1:0] word, input int pos,
			input logic valid);
		logic lit;
		lit = (pos == 0);
		for (int j = pos; j < DIGITS; j++) begin
			if (word[j*4 +: 4] != 4'd0) begin
				lit = 1'b1;
			end
		end
		if (!valid || !lit) begin
			return DARK;
		end
		return seg_ref(int'(word[pos*4 +: 4]));
	endfunction

	function automatic int pow10(input int n);
		int p;
		p = 1;
		for (int i = 0; i < n; i++) begin
			p = p * 10;
		end
		return p;
	endfunction

	function automatic int onehot_index(input logic [DIGITS-1:0] sel);
		int idx;
		int ones;
		idx  = -1;
		ones = 0;
		for (int i = 0; i < DIGITS; i++) begin
			if (sel[i]) begin
				ones = ones + 1;
				idx  = i;
			end
		end
		return (ones == 1) ? idx : -1;
	endfunction

	// --------------------
	// Checks
	// --------------------

	task automatic abort(input string why);
		$display("tests failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			abort("a checked value did not match");
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= LIMIT) begin
			abort("the run went past its cycle limit without finishing");
		end
	end

	// The display checker samples on the falling edge where everything is settled.
	always @(negedge clk) begin
		if (rst) begin
			check("digit_sel", 32'(digit_sel), 32'(1) << scan_pos);
			check("seg", 32'(seg), 32'(exp_seg(disp_word, scan_pos, disp_valid)));
			if (done) begin
				if (pending.size() == 0) begin
					abort("done pulsed with no conversion pending");
				end
				disp_word  = pending.pop_front();	// Shown from the next cycle on.
				disp_valid = 1'b1;
			end
			if (scan_dwell == SCAN_DIV - 1) begin
				scan_dwell = 0;
				scan_pos   = (scan_pos == DIGITS - 1) ? 0 : scan_pos + 1;
			end else begin
				scan_dwell = scan_dwell + 1;
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic start_conversion(input int value);
		bin_value = BIN_BITS'(value);
		start     = 1'b1;
		pending.push_back(to_bcd(value));
	endtask

	// poke_cycle gives the cycle of an extra start while busy or -1 for none.
	task automatic wait_result(input int value, input int poke_cycle, input int poke_value);
		int cycles;
		cycles = 0;
		do begin
			step();
			cycles = cycles + 1;
			if (cycles == poke_cycle) begin
				bin_value = BIN_BITS'(poke_value);
				start     = 1'b1;
			end else begin
				start = 1'b0;
			end
			if (!done) begin
				check("busy", 32'(busy), 32'(1));
				if (cycles > BIN_BITS + 8) begin
					abort("done never arrived after a start");
				end
			end
		end while (!done);
		check("done_cycle", cycles, BIN_BITS + 2);
		check("bcd", 32'(bcd), 32'(to_bcd(value)));
		check("busy", 32'(busy), 32'(0));
	endtask

	// One full scan after a done compares every position with the decimal value.
	task automatic check_display(input int value);
		logic [DIGITS-1:0] visited;
		logic [6:0]        expected;
		int                idx;
		int                prev;
		visited = '0;
		prev    = -1;
		for (int c = 0; c < SCAN_DIV * DIGITS; c++) begin
			step();
			if (c == 0) begin
				check("done", 32'(done), 32'(0));
			end
			idx = onehot_index(digit_sel);
			if (idx < 0) begin
				abort("digit_sel does not select exactly one digit");
			end
			if (prev >= 0 && idx != prev && idx != (prev + 1) % DIGITS) begin
				abort("digit_sel skipped a position");
			end
			visited[idx] = 1'b1;
			prev         = idx;
			if (idx < num_digits(value)) begin
				expected = seg_ref((value / pow10(idx)) % 10);
			end else begin
				expected = DARK;
			end
			check("seg", 32'(seg), 32'(expected));
		end
		check("digits_visited", 32'(visited), 32'((1 << DIGITS) - 1));
	endtask

	initial begin : stimulus
		int fixed_values[N_FIXED];
		int value;
		void'($urandom(32'h009b1a9b));
		start          = 1'b0;
		bin_value      = '0;
		fixed_values   = '{0, 9, 10, 99, 100, 999, 1023};

		wait (rst === 1'b1);
		check("busy", 32'(busy), 32'(0));
		check("done", 32'(done), 32'(0));
		check("bcd", 32'(bcd), 32'(0));
		check("digit_sel", 32'(digit_sel), 32'(1));
		check("seg", 32'(seg), 32'(DARK));
		repeat (2 * SCAN_DIV * DIGITS) begin
			step();
			check("seg", 32'(seg), 32'(DARK));	// Nothing loaded yet.
		end

		// --------------------
		// Fixed values
		// --------------------
		for (int i = 0; i < N_FIXED; i++) begin
			start_conversion(fixed_values[i]);
			wait_result(fixed_values[i], -1, 0);
			check_display(fixed_values[i]);
		end

		// --------------------
		// Random values, back to back
		// --------------------
		for (int k = 0; k < N_RANDOM; k++) begin
			value = int'($urandom % 32'(1 << BIN_BITS));
			start_conversion(value);
			wait_result(value, -1, 0);
		end

		// --------------------
		// Start while busy
		// --------------------
		start_conversion(357);
		wait_result(357, 3, 642);
		check_display(357);
		repeat (2 * SCAN_DIV * DIGITS) step();
		check("bcd", 32'(bcd), 32'(to_bcd(357)));

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
logic/num_fmt_pkg.sv
logic/disp_pkg.sv
logic/bin_to_bcd.sv
logic/digit_scan.sv
logic/readout_top.sv
tests/tb_clock.sv
tests/tb_readout.sv
